/* filelist.f */
+incdir+hw
hw/coreMemPkg.sv
hw/fabricPkg.sv
hw/memPortIf.sv
hw/dataMemory.sv
hw/transFifo.sv
hw/coreReqRouter.sv
hw/fabricReqServer.sv
hw/fabricOutArbiter.sv
hw/tileMemWrap.sv
sim/tileMemClock.sv
sim/tileMemTb.sv

/* hw/coreMemPkg.sv */
/*
 * Core-side memory types
 * Data word, address, byte enables and word indexing
 */
`default_nettype none

`include "tileMem_params.svh"

package coreMemPkg;

   // Core bus
   typedef logic [`DATA_WIDTH-1:0]    tData;
   typedef logic [`ADDR_WIDTH-1:0]    tAddr;
   typedef logic [`BYTE_EN_WIDTH-1:0] tByteEn;   // Lane mask, bit 0 is the low byte

   // Word index into the data memory
   typedef logic [`MEM_INDEX_WIDTH-1:0] tMemIndex;

   // Byte lane inside a word, low address bits
   typedef logic [$clog2(`BYTE_EN_WIDTH)-1:0] tByteOffset;

endpackage

`default_nettype wire

/* hw/coreReqRouter.sv */
/*
 * Core request router
 * Local accesses go to port A with lane alignment, remote ones to the
 * request queue. Holds the core while a remote read is outstanding.
 */
`timescale 1ns/1ns
`default_nettype none

`include "tileMem_params.svh"

module coreReqRouter (
   input var logic                 Clock,
   input var logic                 reset,
   input var fabricPkg::tTileId    localTileId,
   input var coreMemPkg::tData     dMemWrData,
   input var coreMemPkg::tAddr     dMemAddress,
   input var coreMemPkg::tByteEn   dMemByteEn,
   input var logic                 dMemWrEn,
   input var logic                 dMemRdEn,
   output coreMemPkg::tData        dMemRdRsp,
   output logic                    dMemReady,
   memPortIf.requester             memPort,
   output logic                    reqPush,
   output fabricPkg::tTileTrans    reqPushData,
   input var logic                 reqFull,
   input var logic                 inFabricValid,
   input var fabricPkg::tTileTrans inFabric
);

   fabricPkg::tTileId      addrTile;
   logic                   isLocal;
   coreMemPkg::tByteOffset byteOffset, offsetQ;
   logic                   outstanding;        // Remote read in flight
   logic                   fabRspValid, fabRspValidQ;
   coreMemPkg::tData       fabRspDataQ;
   logic                   rdEnQ;              // Local read one stage on
   coreMemPkg::tData       localRdData;

   // ==================================================
   // Address decode
   // ==================================================
   assign addrTile   = dMemAddress[`TILE_ID_LSB +: `TILE_ID_WIDTH];
   assign isLocal    = (addrTile == '0) || (addrTile == localTileId);
   assign byteOffset = dMemAddress[$bits(coreMemPkg::tByteOffset)-1:0];

   // Local access on port A, data and lanes moved up to the offset
   assign memPort.index  = dMemAddress[$bits(coreMemPkg::tByteOffset) +: `MEM_INDEX_WIDTH];
   assign memPort.wrData = dMemWrData << {byteOffset, 3'b000};
   assign memPort.byteEn = dMemByteEn << byteOffset;
   assign memPort.wrEn   = dMemWrEn && isLocal;

   // ==================================================
   // Remote requests into the queue
   // ==================================================
   assign reqPush = (dMemWrEn || dMemRdEn) && !isLocal;

   always_comb begin
      reqPushData.address     = dMemAddress;   // Full address, tile id included
      reqPushData.data        = dMemWrData;
      reqPushData.requestorId = localTileId;
      if (dMemWrEn) begin
         reqPushData.opcode = fabricPkg::WR;
      end else begin
         reqPushData.opcode = fabricPkg::RD;
      end
   end

   // Response to our own remote read
   assign fabRspValid = outstanding && inFabricValid && (inFabric.opcode == fabricPkg::RD_RSP);

   always_ff @(posedge Clock) begin
      if (reset) begin
         outstanding  <= 1'b0;
         fabRspValidQ <= 1'b0;
         rdEnQ        <= 1'b0;
      end else begin
         if (fabRspValid) begin
            outstanding <= 1'b0;
         end else if (dMemRdEn && !isLocal) begin
            outstanding <= 1'b1;   // Core stalls from next cycle
         end
         fabRspValidQ <= fabRspValid;
         rdEnQ        <= dMemRdEn && isLocal;
      end
   end

   // Core held off on a pending read or a full queue
   assign dMemReady = !outstanding && !reqFull;

   // ==================================================
   // Read return path
   // ==================================================
   always_ff @(posedge Clock) begin
      offsetQ     <= byteOffset;      // Lines up with memory read data
      fabRspDataQ <= inFabric.data;
   end

   assign localRdData = memPort.rdData >> {offsetQ, 3'b000};   // Zero fill from top

   // Second stage, fabric response wins; holds between results
   always_ff @(posedge Clock) begin
      if (fabRspValidQ) begin
         dMemRdRsp <= fabRspDataQ;
      end else if (rdEnQ) begin
         dMemRdRsp <= localRdData;
      end
   end

endmodule

`default_nettype wire

/* hw/dataMemory.sv */
/*
 * Data memory
 * True dual-port RAM, byte-enabled writes, one-cycle registered reads
 */
`timescale 1ns/1ns
`default_nettype none

`include "tileMem_params.svh"

module dataMemory (
   input var logic  Clock,
   memPortIf.memory portA,   // Core side
   memPortIf.memory portB    // Fabric side
);

   coreMemPkg::tData mem [2**`MEM_INDEX_WIDTH];

   always_ff @(posedge Clock) begin
      // Port A write, lane by lane
      for (int a = 0; a < `BYTE_EN_WIDTH; a++) begin
         if (portA.wrEn && portA.byteEn[a]) begin
            mem[portA.index][8*a +: 8] <= portA.wrData[8*a +: 8];
         end
      end

      // Port B write
      for (int b = 0; b < `BYTE_EN_WIDTH; b++) begin
         if (portB.wrEn && portB.byteEn[b]) begin
            mem[portB.index][8*b +: 8] <= portB.wrData[8*b +: 8];
         end
      end

      // Reads see the old word on a same-cycle write
      portA.rdData <= mem[portA.index];
      portB.rdData <= mem[portB.index];
   end

endmodule

`default_nettype wire

/* hw/fabricOutArbiter.sv */
/*
 * Outgoing fabric arbiter
 * Round-robin between response and request queues, same-cycle grant
 */
`timescale 1ns/1ns
`default_nettype none

module fabricOutArbiter (
   input var logic                 Clock,
   input var logic                 reset,
   input var logic                 rspEmpty,
   input var fabricPkg::tTileTrans rspData,
   input var logic                 reqEmpty,
   input var fabricPkg::tTileTrans reqData,
   input var fabricPkg::tFabReady  fabReady,
   output logic                    rspPop,
   output logic                    reqPop,
   output logic                    outFabricValid,
   output fabricPkg::tTileTrans    outFabric
);

   typedef enum logic {
      GRANT_RSP = 1'b0,
      GRANT_REQ = 1'b1
   } tGrant;

   tGrant lastGrant;   // Who won the last contended or lone grant
   logic  allReady;
   logic  rspElig, reqElig;

   // Naive back-pressure: wait for every fabric lane
   assign allReady = &fabReady;
   assign rspElig  = !rspEmpty && allReady;
   assign reqElig  = !reqEmpty && allReady;

   // Tie goes to the side not served last
   assign rspPop = rspElig && (!reqElig || (lastGrant == GRANT_REQ));
   assign reqPop = reqElig && (!rspElig || (lastGrant == GRANT_RSP));

   assign outFabricValid = rspPop || reqPop;
   assign outFabric      = rspPop ? rspData : (reqPop ? reqData : '0);

   always_ff @(posedge Clock) begin
      if (reset) begin
         lastGrant <= GRANT_REQ;   // Responses first after reset
      end else if (rspPop) begin
         lastGrant <= GRANT_RSP;
      end else if (reqPop) begin
         lastGrant <= GRANT_REQ;
      end
   end

endmodule

`default_nettype wire

/* hw/fabricPkg.sv */
/*
 * Fabric transaction types
 * Opcode, tile id, ready lines and the transaction packet
 */
`default_nettype none

`include "tileMem_params.svh"

package fabricPkg;

   // ==================================================
   // Identifiers and flow control
   // ==================================================
   typedef logic [`TILE_ID_WIDTH-1:0]   tTileId;
   typedef logic [`FAB_READY_WIDTH-1:0] tFabReady;   // One per downstream queue

   typedef enum logic [1:0] {
      RD     = 2'b00,   // Read request
      WR     = 2'b01,   // Full-word write
      RD_RSP = 2'b10    // Read response back to requestor
   } tOpcode;

   // ==================================================
   // Transaction packet, 74 bits
   // ==================================================
   typedef struct packed {
      coreMemPkg::tAddr address;   // Target tile id in top byte
      coreMemPkg::tData data;
      tOpcode           opcode;
      tTileId           requestorId; // Where a response goes
   } tTileTrans;

endpackage

`default_nettype wire

/* hw/fabricReqServer.sv */
/*
 * Fabric request server
 * Writes incoming WR to port B, answers RD with a queued RD_RSP
 */
`timescale 1ns/1ns
`default_nettype none

`include "tileMem_params.svh"

module fabricReqServer (
   input var logic                 Clock,
   input var logic                 reset,
   input var fabricPkg::tTileId    localTileId,
   input var logic                 inFabricValid,
   input var fabricPkg::tTileTrans inFabric,
   memPortIf.requester             memPort,
   output logic                    rspPush,
   output fabricPkg::tTileTrans    rspPushData
);

   logic              rdReq;
   coreMemPkg::tAddr  rspAddrQ;   // Response header, one cycle on
   fabricPkg::tTileId rspIdQ;

   // Every fabric access targets the data memory
   assign memPort.index  = inFabric.address[$bits(coreMemPkg::tByteOffset) +: `MEM_INDEX_WIDTH];
   assign memPort.wrData = inFabric.data;
   assign memPort.byteEn = '1;   // Whole word
   assign memPort.wrEn   = inFabricValid && (inFabric.opcode == fabricPkg::WR);

   assign rdReq = inFabricValid && (inFabric.opcode == fabricPkg::RD);

   always_ff @(posedge Clock) begin
      if (reset) begin
         rspPush <= 1'b0;
      end else begin
         rspPush <= rdReq;   // Memory word ready next cycle
      end
   end

   // Header, address points back at the requestor tile
   always_ff @(posedge Clock) begin
      rspAddrQ <= {inFabric.requestorId, inFabric.address[`TILE_ID_LSB-1:0]};
      rspIdQ   <= localTileId;
   end

   always_comb begin
      rspPushData.address     = rspAddrQ;
      rspPushData.data        = memPort.rdData;   // Read on previous edge
      rspPushData.opcode      = fabricPkg::RD_RSP;
      rspPushData.requestorId = rspIdQ;
   end

endmodule

`default_nettype wire

/* hw/memPortIf.sv */
/*
 * One data-memory port
 * Word index, byte-enabled write, registered read data
 */
`timescale 1ns/1ns
`default_nettype none

`include "tileMem_params.svh"

interface memPortIf;

   logic [`MEM_INDEX_WIDTH-1:0] index;    // Word address
   logic [`DATA_WIDTH-1:0]      wrData;
   logic [`BYTE_EN_WIDTH-1:0]   byteEn;
   logic                        wrEn;
   logic [`DATA_WIDTH-1:0]      rdData;   // Word at index of previous edge

   // Block that issues accesses
   modport requester (output index, wrData, byteEn, wrEn, input rdData);

   // The RAM itself
   modport memory (input index, wrData, byteEn, wrEn, output rdData);

endinterface

`default_nettype wire

/* hw/tileMemWrap.sv */
/*
 * Tile data-memory wrapper, top level
 * Core and fabric access to one dual-port data memory
 */
`timescale 1ns/1ns
`default_nettype none

module tileMemWrap (
   input var logic                 Clock,
   input var logic                 reset,
   input var fabricPkg::tTileId    localTileId,
   // Core data port
   input var coreMemPkg::tData     dMemWrData,
   input var coreMemPkg::tAddr     dMemAddress,
   input var coreMemPkg::tByteEn   dMemByteEn,
   input var logic                 dMemWrEn,
   input var logic                 dMemRdEn,
   output coreMemPkg::tData        dMemRdRsp,
   output logic                    dMemReady,
   // Fabric ingress
   input var logic                 inFabricValid,
   input var fabricPkg::tTileTrans inFabric,
   output logic                    bigCoreReady,
   // Fabric egress
   output logic                    outFabricValid,
   output fabricPkg::tTileTrans    outFabric,
   input var fabricPkg::tFabReady  fabReady
);

   logic                 reqPush, reqFull, reqPop, reqEmpty;
   fabricPkg::tTileTrans reqPushData, reqPopData;
   logic                 rspPush, rspPop, rspEmpty, rspAlmostFull;
   fabricPkg::tTileTrans rspPushData, rspPopData;

   memPortIf portA ();   // Core
   memPortIf portB ();   // Fabric

   dataMemory dataMem (.Clock, .portA(portA.memory), .portB(portB.memory));

   coreReqRouter coreRouter (
      .Clock, .reset, .localTileId,
      .dMemWrData, .dMemAddress, .dMemByteEn, .dMemWrEn, .dMemRdEn,
      .dMemRdRsp, .dMemReady,
      .memPort(portA.requester),
      .reqPush, .reqPushData, .reqFull,
      .inFabricValid, .inFabric
   );

   fabricReqServer fabServer (
      .Clock, .reset, .localTileId, .inFabricValid, .inFabric,
      .memPort(portB.requester), .rspPush, .rspPushData
   );

   // ==================================================
   // Outgoing queues and merge
   // ==================================================
   transFifo reqFifo (
      .Clock, .reset, .push(reqPush), .pushData(reqPushData), .pop(reqPop),
      .popData(reqPopData), .full(reqFull), .almostFull(), .empty(reqEmpty)
   );

   transFifo rspFifo (
      .Clock, .reset, .push(rspPush), .pushData(rspPushData), .pop(rspPop),
      .popData(rspPopData), .full(), .almostFull(rspAlmostFull), .empty(rspEmpty)
   );

   fabricOutArbiter outArbiter (
      .Clock, .reset,
      .rspEmpty, .rspData(rspPopData), .reqEmpty, .reqData(reqPopData),
      .fabReady, .rspPop, .reqPop, .outFabricValid, .outFabric
   );

   assign bigCoreReady = !rspAlmostFull;   // Keep a slot for the read in flight

endmodule

`default_nettype wire

/* hw/tileMem_params.svh */
/*
 * Tile data-memory wrapper
 * Widths, memory and queue depths, tile-id field position
 */
`ifndef TILE_MEM_PARAMS_SVH
`define TILE_MEM_PARAMS_SVH

// Word and address widths
`define DATA_WIDTH      32
`define ADDR_WIDTH      32
`define BYTE_EN_WIDTH   4   // One enable per byte lane

// Tile id lives in the top address byte
`define TILE_ID_WIDTH   8
`define TILE_ID_LSB     24

`define MEM_INDEX_WIDTH 10  // 1024 words of data memory
`define FIFO_DEPTH      2   // Entries per outgoing queue
`define FAB_READY_WIDTH 4   // Ready lines from the fabric

`endif

/* hw/transFifo.sv */
/*
 * Transaction queue
 * Small circular buffer with occupancy count and full/almost-full/empty
 */
`timescale 1ns/1ns
`default_nettype none

`include "tileMem_params.svh"

module transFifo (
   input var logic                 Clock,
   input var logic                 reset,
   input var logic                 push,
   input var fabricPkg::tTileTrans pushData,
   input var logic                 pop,
   output fabricPkg::tTileTrans    popData,
   output logic                    full,
   output logic                    almostFull,
   output logic                    empty
);

   typedef logic [$clog2(`FIFO_DEPTH)-1:0] tPtr;
   typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] tCount;

   fabricPkg::tTileTrans entries [`FIFO_DEPTH];
   tPtr                  wrPtr, rdPtr;
   tCount                count;
   logic                 doPush, doPop;

   assign doPush = push && !full;    // Overflow dropped
   assign doPop  = pop && !empty;

   always_ff @(posedge Clock) begin
      if (doPush) begin
         entries[wrPtr] <= pushData;
      end
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (doPush) begin
            wrPtr <= (wrPtr == tPtr'(`FIFO_DEPTH-1)) ? '0 : wrPtr + 1'b1;
         end
         if (doPop) begin
            rdPtr <= (rdPtr == tPtr'(`FIFO_DEPTH-1)) ? '0 : rdPtr + 1'b1;
         end
         if (doPush && !doPop) begin
            count <= count + 1'b1;
         end else if (doPop && !doPush) begin
            count <= count - 1'b1;
         end
      end
   end

   assign popData    = entries[rdPtr];   // Head, valid when not empty
   assign full       = (count == tCount'(`FIFO_DEPTH));
   assign almostFull = (count >= tCount'(`FIFO_DEPTH-1));   // One slot of margin
   assign empty      = (count == '0);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the tile memory testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tileMemTb -f filelist.f \
   -o tileMemSim || { echo "Build failed"; exit 1; }
./obj_dir/tileMemSim > sim.log 2>&1
grep -q "RESULT: PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* sim/tileMemClock.sv */
/*
 * Testbench clock and reset
 * 20 ns clock, reset held high for the first 8 rising edges
 */
`timescale 1ns/1ns
`default_nettype none

module tileMemClock (
   output logic Clock,
   output logic reset
);

   initial begin
      Clock = 1'b0;
      forever #10 Clock = ~Clock;   // 50 MHz
   end

   initial begin
      reset = 1'b1;
      repeat (8) @(posedge Clock);
      @(negedge Clock);
      reset = 1'b0;   // Released between edges
   end

endmodule

`default_nettype wire

/* sim/tileMemTb.sv */
/*
 * Testbench for the tile data-memory wrapper
 * Random core and fabric traffic, checked every cycle against a reference model
 */
`timescale 1ns/1ns
`default_nettype none

`include "tileMem_params.svh"

module tileMemTb;

   localparam int                numCycles = 2000;
   localparam fabricPkg::tTileId localId   = 8'h05;

   logic                 Clock, reset;
   fabricPkg::tTileId    localTileId;
   coreMemPkg::tData     dMemWrData, dMemRdRsp;
   coreMemPkg::tAddr     dMemAddress;
   coreMemPkg::tByteEn   dMemByteEn;
   logic                 dMemWrEn, dMemRdEn, dMemReady;
   logic                 inFabricValid, bigCoreReady, outFabricValid;
   fabricPkg::tTileTrans inFabric, outFabric;
   fabricPkg::tFabReady  fabReady;

   // ==================================================
   // Reference model
   // ==================================================
   coreMemPkg::tData     memModel [2**`MEM_INDEX_WIDTH];
   fabricPkg::tTileTrans reqModel [$];          // Expected request queue
   fabricPkg::tTileTrans rspModel [$];          // Expected response queue
   fabricPkg::tTileTrans reqStaged, rspStaged, rspPending;
   logic                 reqStagedValid, rspStagedValid, rspPendingValid;
   coreMemPkg::tData     rdDueData [$];         // Expected dMemRdRsp values
   int                   rdDueCycle [$];        // and the cycle each is due
   logic                 outstanding;           // Remote read in flight
   logic                 lastWasRsp;            // Last outgoing grant
   int                   cycle;
   int                   waitCount;
   integer               seed;

   tileMemClock clockGen (.Clock, .reset);

   tileMemWrap uut (
      .Clock, .reset, .localTileId,
      .dMemWrData, .dMemAddress, .dMemByteEn, .dMemWrEn, .dMemRdEn, .dMemRdRsp, .dMemReady,
      .inFabricValid, .inFabric, .bigCoreReady, .outFabricValid, .outFabric, .fabReady
   );

   task automatic stopOnError(input string line);
      $display("%s", line);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   // Initial contents, every index bit shows up twice
   function automatic coreMemPkg::tData fillWord(input coreMemPkg::tMemIndex idx);
      return {6'h2A, idx, ~idx, 6'h15};
   endfunction

   // Core request, model effect staged until the clock edge
   task automatic sendCore(input logic isWrite, input coreMemPkg::tAddr addr,
         input coreMemPkg::tData data, input coreMemPkg::tByteEn be);
      coreMemPkg::tMemIndex   idx;
      coreMemPkg::tByteOffset off;
      fabricPkg::tTileId      tile;
      int                     src;
      idx  = addr[2 +: `MEM_INDEX_WIDTH];
      off  = addr[1:0];
      tile = addr[`TILE_ID_LSB +: `TILE_ID_WIDTH];
      dMemAddress = addr;
      dMemWrData  = data;
      dMemByteEn  = be;
      dMemWrEn    = isWrite;
      dMemRdEn    = !isWrite;
      if (tile != 8'h00 && tile != localId) begin
         reqStaged      = {addr, data, isWrite ? fabricPkg::WR : fabricPkg::RD, localId};
         reqStagedValid = 1'b1;
         outstanding    = outstanding || !isWrite;
      end else if (isWrite) begin
         for (int lane = 0; lane < `BYTE_EN_WIDTH; lane++) begin
            src = lane - int'(off);   // Source lane moves up by the offset
            if (src >= 0 && be[src]) memModel[idx][8*lane +: 8] = data[8*src +: 8];
         end
      end else begin
         rdDueData.push_back(memModel[idx] >> (8 * off));   // Zero filled from the top
         rdDueCycle.push_back(cycle + 2);
      end
   endtask

   task automatic sendFabric(input fabricPkg::tOpcode op, input coreMemPkg::tMemIndex idx,
         input coreMemPkg::tData data);
      fabricPkg::tTileId srcTile;
      srcTile       = 8'h10 + fabricPkg::tTileId'($random(seed) & 15);   // Some remote tile
      inFabricValid = 1'b1;
      inFabric      = {{localId, 12'($random(seed)), idx, 2'b00}, data, op, srcTile};
      if (op == fabricPkg::WR) begin
         memModel[idx] = data;
      end else if (op == fabricPkg::RD) begin
         rspStaged      = {{srcTile, inFabric.address[`TILE_ID_LSB-1:0]}, memModel[idx],
                           fabricPkg::RD_RSP, localId};
         rspStagedValid = 1'b1;
      end else begin
         outstanding = 1'b0;   // Our remote read answered
         rdDueData.push_back(data);
         rdDueCycle.push_back(cycle + 2);
      end
   endtask

   // ==================================================
   // Per-cycle stimulus and checks
   // ==================================================
   task automatic checkRegistered();
      assert (dMemReady === (!outstanding && reqModel.size() < `FIFO_DEPTH))
         else stopOnError($sformatf("Fail at %0t ns: dMemReady is %b", $time, dMemReady));
      assert (bigCoreReady === (rspModel.size() < `FIFO_DEPTH - 1))
         else stopOnError($sformatf("Fail at %0t ns: bigCoreReady is %b", $time, bigCoreReady));
      if (rdDueCycle.size() > 0 && rdDueCycle[0] == cycle) begin
         assert (dMemRdRsp === rdDueData[0])
            else stopOnError($sformatf("Fail at %0t ns: dMemRdRsp %h, expected %h",
                                       $time, dMemRdRsp, rdDueData[0]));
         void'(rdDueCycle.pop_front());
         void'(rdDueData.pop_front());
      end
   endtask

   task automatic checkOutgoing();
      logic                 rspElig, reqElig, pickRsp;
      fabricPkg::tTileTrans expTrans;
      rspElig = rspModel.size() > 0 && fabReady == '1;   // Every ready line high
      reqElig = reqModel.size() > 0 && fabReady == '1;
      pickRsp = rspElig && (!reqElig || !lastWasRsp);   // Alternate on a tie
      assert (outFabricValid === (rspElig || reqElig))
         else stopOnError($sformatf("Fail at %0t ns: outFabricValid is %b", $time, outFabricValid));
      if (rspElig || reqElig) begin
         expTrans   = pickRsp ? rspModel.pop_front() : reqModel.pop_front();
         lastWasRsp = pickRsp;
         assert (outFabric === expTrans)
            else stopOnError($sformatf("Fail at %0t ns: outFabric %h, expected %h",
                                       $time, outFabric, expTrans));
      end
   endtask

   // Mode 0 fills memory, 1 is random traffic, 2 only drains
   task automatic driveInputs(input int mode, input int fillIdx);
      int                     kind;
      coreMemPkg::tMemIndex   idx;
      coreMemPkg::tByteOffset off;
      fabricPkg::tTileId      tile;
      dMemWrEn       = 1'b0;
      dMemRdEn       = 1'b0;
      inFabricValid  = 1'b0;
      reqStagedValid = 1'b0;
      rspStagedValid = 1'b0;
      fabReady       = '1;
      if (mode == 0) begin
         idx = coreMemPkg::tMemIndex'(fillIdx);
         sendCore(1'b1, {8'h00, 12'h000, idx, 2'b00}, fillWord(idx), 4'hF);
         sendFabric(fabricPkg::WR, idx + 10'd512, fillWord(idx + 10'd512));
      end else if (mode == 2) begin
         if (outstanding) sendFabric(fabricPkg::RD_RSP, '0, $random(seed));
      end else begin
         if (($random(seed) & 3) == 0) fabReady = fabricPkg::tFabReady'($random(seed));
         // Fabric first, so an RD_RSP never meets a read issued in the same cycle
         kind = $random(seed) & 7;
         idx  = coreMemPkg::tMemIndex'(512 + ($random(seed) & 511));   // Upper half
         if (outstanding && kind >= 4) sendFabric(fabricPkg::RD_RSP, '0, $random(seed));
         else if (bigCoreReady && kind == 0) sendFabric(fabricPkg::RD, idx, $random(seed));
         else if (bigCoreReady && kind == 1) sendFabric(fabricPkg::WR, idx, $random(seed));
         if (dMemReady) begin
            kind = $random(seed) & 7;
            off  = coreMemPkg::tByteOffset'($random(seed));
            idx  = coreMemPkg::tMemIndex'($random(seed) & 511);   // Lower half
            tile = ($random(seed) & 1) ? localId : 8'h00;         // Both local forms
            if (kind == 0) begin
               sendCore(1'b1, {tile, 12'h000, idx, off}, $random(seed), 4'b0001);
            end else if (kind == 1) begin
               sendCore(1'b1, {tile, 12'h000, idx, off[1], 1'b0}, $random(seed), 4'b0011);
            end else if (kind == 2) begin
               sendCore(1'b1, {tile, 12'h000, idx, 2'b00}, $random(seed), 4'b1111);
            end else if (kind <= 4) begin
               sendCore(1'b0, {tile, 12'h000, idx, off}, $random(seed), '0);
            end else if (kind <= 6) begin
               tile = 8'h40 | fabricPkg::tTileId'($random(seed));   // Never 0 or 05
               sendCore(kind == 5, {tile, 24'($random(seed))}, $random(seed), 4'hF);
            end
         end
      end
   endtask

   task automatic stepCycle(input int mode, input int fillIdx);
      @(negedge Clock);
      checkRegistered();
      driveInputs(mode, fillIdx);
      #1;
      checkOutgoing();
      if (rspPendingValid) rspModel.push_back(rspPending);   // One edge after its RD
      rspPending      = rspStaged;
      rspPendingValid = rspStagedValid;
      if (reqStagedValid) reqModel.push_back(reqStaged);
      cycle++;
   endtask

   // ==================================================
   // Test sequence
   // ==================================================
   initial begin
      seed            = 32'h2690;
      cycle           = 0;
      outstanding     = 1'b0;
      lastWasRsp      = 1'b0;   // Responses favored first after reset
      rspPendingValid = 1'b0;
      localTileId     = localId;
      dMemWrData      = '0;
      dMemAddress     = '0;
      dMemByteEn      = '0;
      dMemWrEn        = 1'b0;
      dMemRdEn        = 1'b0;
      inFabricValid   = 1'b0;
      inFabric        = '0;
      fabReady        = '1;

      waitCount = 0;
      while (reset !== 1'b0) begin
         @(negedge Clock);
         waitCount++;
         if (waitCount > 20) stopOnError("Timed out waiting for reset to be released");
      end
      assert (outFabricValid === 1'b0 && dMemReady === 1'b1 && bigCoreReady === 1'b1)
         else stopOnError($sformatf("Fail at %0t ns: wrong outputs after reset", $time));

      for (int i = 0; i < 512; i++) stepCycle(0, i);
      repeat (numCycles) stepCycle(1, 0);

      // Let every expected transaction and read result come out
      waitCount = 0;
      while (reqModel.size() + rspModel.size() + rdDueCycle.size() != 0
             || rspPendingValid || outstanding) begin
         stepCycle(2, 0);
         waitCount++;
         if (waitCount > 50) stopOnError("Timed out draining the outgoing queues");
      end
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire
